/* common/cacheGeomPkg.sv */
// Cache geometry constants
`default_nettype none

package cacheGeomPkg;

    // byte address width of the load/store path
    parameter int addrBits = 18;

    // 64 sets of one word each
    parameter int defaultIndexBits = 6;

    // addr[17:16] == 2'b11 selects the uncached IO region
    parameter logic [1:0] ioRegionTop = 2'd3;

endpackage

`default_nettype wire

/* common/memAccessPkg.sv */
// Memory access types
`default_nettype none

package memAccessPkg;

    // access size of a load or store
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen;

    typedef logic [31:0] wordT;
    typedef logic [cacheGeomPkg::addrBits-1:0] addrT;

    // request from the load/store unit
    typedef struct packed {
        logic     rw;     // 1 = store
        accessLen len;
        addrT     addr;
        wordT     sdata;
    } lsReq;

    // request from the cache to the byte sequencer
    typedef struct packed {
        logic     rw;
        accessLen len;
        addrT     addr;
        wordT     sdata;  // store data, or the victim line on writeback
    } memReq;

endpackage

`default_nettype wire

/* dcache/dcacheArray.sv */
// Cache tag and data array
`timescale 1ns/10ps
`default_nettype none

module dcacheArray #(
    parameter int indexBits = cacheGeomPkg::defaultIndexBits,
    localparam int tagBits = cacheGeomPkg::addrBits - indexBits - 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire [indexBits-1:0]      index,
    input  wire [tagBits-1:0]        tag,
    input  wire                      we,
    input  wire                      wDirty,
    input  wire [tagBits-1:0]        wTag,
    input  wire memAccessPkg::wordT  wData,
    output logic                     hit,
    output logic                     victimDirty,
    output logic [tagBits-1:0]       victimTag,
    output memAccessPkg::wordT       lineData
);
    localparam int sets = 1 << indexBits;

    memAccessPkg::wordT dataMem [sets];
    logic [tagBits-1:0] tagMem [sets];
    logic [sets-1:0] validVec;
    logic [sets-1:0] dirtyVec;

    // combinational read, same cycle as the request
    assign hit = validVec[index] && (tagMem[index] == tag);
    assign victimDirty = validVec[index] && dirtyVec[index];
    assign victimTag = tagMem[index];
    assign lineData = dataMem[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            validVec <= '0;
            dirtyVec <= '0;
        end else if (rdy && we) begin
            validVec[index] <= 1'b1;
            dirtyVec[index] <= wDirty;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && we) begin
            dataMem[index] <= wData;
            tagMem[index] <= wTag;
        end
    end

endmodule

`default_nettype wire

/* dcache/laneAlign.sv */
// Byte lane alignment
`timescale 1ns/10ps
`default_nettype none

module laneAlign (
    input  wire memAccessPkg::accessLen len,
    input  wire [1:0]                   offset,
    input  wire memAccessPkg::wordT     sdata,
    input  wire memAccessPkg::wordT     lineData,
    output memAccessPkg::wordT          mergedWord,
    output memAccessPkg::wordT          laneWord
);
    logic [4:0] sh;
    memAccessPkg::wordT shifted;
    memAccessPkg::wordT mask;

    always_comb begin
        sh = {offset, 3'b000};   // byte offset in bits
        shifted = lineData >> sh;
        mask = (len == memAccessPkg::lenByte) ? 32'h0000_00ff : 32'h0000_ffff;

        halfLanes: assert #0 (len !== memAccessPkg::lenHalf || offset !== 2'b11)
            else $error("halfword access at offset 3");

        if (len == memAccessPkg::lenWord) begin
            mergedWord = sdata;
            laneWord = lineData;
        end else begin
            // replace the addressed lanes, keep the rest of the line
            mergedWord = (lineData & ~(mask << sh)) | ((sdata & mask) << sh);
            laneWord = shifted & mask;   // zero extend
        end
    end

endmodule

`default_nettype wire

/* dcache/dcacheCtrl.sv */
// Data cache controller
`timescale 1ns/10ps
`default_nettype none

module dcacheCtrl #(
    parameter int indexBits = cacheGeomPkg::defaultIndexBits,
    localparam int tagBits = cacheGeomPkg::addrBits - indexBits - 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      lsEn,
    input  wire memAccessPkg::lsReq  req,
    input  wire                      hit,
    input  wire                      victimDirty,
    input  wire [tagBits-1:0]        victimTag,
    input  wire memAccessPkg::wordT  lineData,
    input  wire memAccessPkg::wordT  mergedWord,
    input  wire memAccessPkg::wordT  laneWord,
    input  wire                      memDone,
    input  wire memAccessPkg::wordT  memRdata,
    output logic                     arrWe,
    output logic                     arrDirty,
    output memAccessPkg::wordT       arrWord,
    output logic                     memEn,
    output memAccessPkg::memReq      mReq,
    output logic                     done,
    output memAccessPkg::wordT       ldData,
    output memAccessPkg::lsReq       heldReq
);
    typedef enum logic [2:0] {stIdle, stWriteback, stRefill, stBypass, stFinish} ctrlState;

    ctrlState state;
    memAccessPkg::lsReq heldQ;
    memAccessPkg::lsReq curReq;
    memAccessPkg::addrT lineAddr;
    memAccessPkg::addrT victimAddr;
    logic isIo;
    logic isWord;
    logic cacheHit;
    logic start;

    // in idle the live request indexes the array, so a hit answers next cycle
    assign curReq = (state == stIdle) ? req : heldQ;
    assign heldReq = curReq;

    assign isIo = curReq.addr[cacheGeomPkg::addrBits-1 -: 2] == cacheGeomPkg::ioRegionTop;
    assign isWord = (curReq.len == memAccessPkg::lenWord) && !isIo;
    assign cacheHit = hit && !isIo;
    assign start = rdy && lsEn && (state == stIdle);

    assign lineAddr = {curReq.addr[cacheGeomPkg::addrBits-1:2], 2'b00};
    assign victimAddr = {victimTag, curReq.addr[indexBits+1:2], 2'b00};

    assign done = rdy && (state == stFinish);

    // array write port: store hit or word allocate, else refill
    always_comb begin
        arrWe = 1'b0;
        arrDirty = 1'b1;
        arrWord = mergedWord;
        if (start && curReq.rw && (cacheHit || isWord)) begin
            arrWe = 1'b1;
        end else if (rdy && (state == stRefill) && memDone) begin
            arrWe = 1'b1;
            arrDirty = 1'b0;   // refilled line matches memory
            arrWord = memRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            memEn <= 1'b0;
        end else if (rdy) begin
            memEn <= 1'b0;
            case (state)
                stIdle: begin
                    if (lsEn) begin
                        if (cacheHit) begin
                            state <= stFinish;
                        end else if (isWord && victimDirty) begin
                            memEn <= 1'b1;
                            state <= stWriteback;
                        end else if (isWord && curReq.rw) begin
                            state <= stFinish;   // allocate without fetch
                        end else if (isWord) begin
                            memEn <= 1'b1;
                            state <= stRefill;
                        end else begin
                            memEn <= 1'b1;
                            state <= stBypass;
                        end
                    end
                end
                stWriteback: begin
                    if (memDone) begin
                        memEn <= !heldQ.rw;   // loads go on to refill
                        state <= heldQ.rw ? stFinish : stRefill;
                    end
                end
                stRefill, stBypass: begin
                    if (memDone) state <= stFinish;
                end
                default: state <= stIdle;   // finish lasts one cycle
            endcase
        end
    end

    // request payload and load result
    always_ff @(posedge clk) begin
        if (start) begin
            heldQ <= req;
            if (cacheHit && !curReq.rw) ldData <= laneWord;
            if (!cacheHit && isWord && victimDirty) begin
                mReq <= '{rw: 1'b1, len: memAccessPkg::lenWord, addr: victimAddr, sdata: lineData};
            end else if (!cacheHit && isWord) begin
                mReq <= '{rw: 1'b0, len: memAccessPkg::lenWord, addr: lineAddr, sdata: '0};
            end else if (!cacheHit) begin
                mReq <= '{rw: curReq.rw, len: curReq.len, addr: curReq.addr, sdata: curReq.sdata};
            end
        end else if (rdy && memDone) begin
            if (state == stWriteback) begin
                mReq <= '{rw: 1'b0, len: memAccessPkg::lenWord, addr: lineAddr, sdata: '0};
            end else if (!heldQ.rw) begin
                ldData <= memRdata;   // sequencer zero-fills unused lanes
            end
        end
    end

    lsEnIdle: assert property (@(posedge clk) disable iff (rst) lsEn |-> state == stIdle)
        else $error("lsEn raised while an access is in progress");

    memEnOnce: assert property (@(posedge clk) disable iff (rst)
        (memEn && rdy) |=> !(memEn && rdy) until memDone)
        else $error("second memEn before memDone");

endmodule

`default_nettype wire

/* design/memByteSeq.sv */
// Memory byte sequencer
`timescale 1ns/10ps
`default_nettype none

module memByteSeq (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      memEn,
    input  wire memAccessPkg::memReq mReq,
    input  wire [7:0]                ramDin,
    output logic                     memDone,
    output memAccessPkg::wordT       memRdata,
    output memAccessPkg::addrT       ramAddr,
    output logic                     ramWr,
    output logic [7:0]               ramDout
);
    memAccessPkg::memReq cur;
    memAccessPkg::addrT issueAddr;
    memAccessPkg::addrT lastAddr;
    logic busy;
    logic [1:0] byteIdx;
    logic [1:0] lastIdx;
    logic capPend;
    logic capLast;
    logic [1:0] capLane;

    function automatic logic [1:0] lastByte(input memAccessPkg::accessLen len);
        case (len)
            memAccessPkg::lenByte: lastByte = 2'd0;
            memAccessPkg::lenHalf: lastByte = 2'd1;
            default:               lastByte = 2'd3;
        endcase
    endfunction

    assign issueAddr = cur.addr + memAccessPkg::addrT'(byteIdx);

    // while stalled the RAM keeps seeing the last issued byte, so the
    // byte that lands after the stall is still the one expected
    assign ramAddr = (rdy && busy) ? issueAddr : lastAddr;
    assign ramWr = rdy && busy && cur.rw;
    assign ramDout = cur.sdata[{byteIdx, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            byteIdx <= 2'd0;
            capPend <= 1'b0;
            memDone <= 1'b0;
        end else if (rdy) begin
            // writes finish after the last byte, reads after it comes back
            memDone <= (busy && cur.rw && byteIdx == lastIdx) || (capPend && capLast);
            capPend <= busy && !cur.rw;
            if (memEn) begin
                busy <= 1'b1;
                byteIdx <= 2'd0;
            end else if (busy) begin
                byteIdx <= byteIdx + 2'd1;
                if (byteIdx == lastIdx) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (memEn) begin
                cur <= mReq;
                lastIdx <= lastByte(mReq.len);
                memRdata <= '0;   // unused lanes read as zero
            end
            if (busy) begin
                lastAddr <= issueAddr;
                capLane <= byteIdx;
                capLast <= byteIdx == lastIdx;
            end
            if (capPend) memRdata[{capLane, 3'b000} +: 8] <= ramDin;
        end
    end

    memEnIdle: assert property (@(posedge clk) disable iff (rst) (memEn && rdy) |-> !busy)
        else $error("memEn while the byte counter is running");

endmodule

`default_nettype wire

/* design/dcacheTop.sv */
// Data cache subsystem top
`timescale 1ns/10ps
`default_nettype none

module dcacheTop #(
    parameter int indexBits = cacheGeomPkg::defaultIndexBits,
    localparam int tagBits = cacheGeomPkg::addrBits - indexBits - 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      lsEn,
    input  wire memAccessPkg::lsReq  req,
    input  wire [7:0]                ramDin,
    output logic                     done,
    output memAccessPkg::wordT       ldData,
    output memAccessPkg::addrT       ramAddr,
    output logic                     ramWr,
    output logic [7:0]               ramDout
);
    memAccessPkg::lsReq heldReq;
    memAccessPkg::memReq mReq;
    memAccessPkg::wordT lineData;
    memAccessPkg::wordT mergedWord;
    memAccessPkg::wordT laneWord;
    memAccessPkg::wordT arrWord;
    memAccessPkg::wordT memRdata;
    logic [tagBits-1:0] victimTag;
    logic hit;
    logic victimDirty;
    logic arrWe;
    logic arrDirty;
    logic memEn;
    logic memDone;

    dcacheCtrl #(.indexBits(indexBits)) ctrl (
        .clk(clk), .rst(rst), .rdy(rdy), .lsEn(lsEn), .req(req),
        .hit(hit), .victimDirty(victimDirty), .victimTag(victimTag),
        .lineData(lineData), .mergedWord(mergedWord), .laneWord(laneWord),
        .memDone(memDone), .memRdata(memRdata),
        .arrWe(arrWe), .arrDirty(arrDirty), .arrWord(arrWord),
        .memEn(memEn), .mReq(mReq), .done(done), .ldData(ldData), .heldReq(heldReq)
    );

    dcacheArray #(.indexBits(indexBits)) array (
        .clk(clk), .rst(rst), .rdy(rdy),
        .index(heldReq.addr[indexBits+1:2]),
        .tag(heldReq.addr[cacheGeomPkg::addrBits-1:indexBits+2]),
        .we(arrWe), .wDirty(arrDirty),
        .wTag(heldReq.addr[cacheGeomPkg::addrBits-1:indexBits+2]),
        .wData(arrWord),
        .hit(hit), .victimDirty(victimDirty), .victimTag(victimTag), .lineData(lineData)
    );

    laneAlign align (
        .len(heldReq.len), .offset(heldReq.addr[1:0]), .sdata(heldReq.sdata),
        .lineData(lineData), .mergedWord(mergedWord), .laneWord(laneWord)
    );

    memByteSeq seq (
        .clk(clk), .rst(rst), .rdy(rdy), .memEn(memEn), .mReq(mReq), .ramDin(ramDin),
        .memDone(memDone), .memRdata(memRdata),
        .ramAddr(ramAddr), .ramWr(ramWr), .ramDout(ramDout)
    );

endmodule

`default_nettype wire

/* sim/ramModel.sv */
// Byte-wide RAM model
`timescale 1ns/10ps
`default_nettype none

module ramModel (
    input  wire                     clk,
    input  wire memAccessPkg::addrT addr,
    input  wire                     wr,
    input  wire [7:0]               din,
    output logic [7:0]              dout,
    output int                      writeCount
);
    localparam int depth = 1 << cacheGeomPkg::addrBits;

    logic [7:0] mem [depth];

    // starts cleared, like the byte model in the testbench
    initial begin
        for (int i = 0; i < depth; i++) mem[i] = 8'h00;
        dout = 8'h00;
        writeCount = 0;
    end

    // read data comes back one cycle after its address
    always @(posedge clk) begin
        dout <= mem[addr];
        if (wr) begin
            mem[addr] <= din;
            writeCount <= writeCount + 1;   // bytes written since start
        end
    end

endmodule

`default_nettype wire

/* sim/dcacheTb.sv */
// Data cache testbench
`timescale 1ns/10ps
`default_nettype none

module dcacheTb;
    localparam int timeoutCycles = 200;

    logic clk;
    logic rst;
    logic rdy;
    logic lsEn;
    memAccessPkg::lsReq req;
    logic [7:0] ramDin;
    logic done;
    memAccessPkg::wordT ldData;
    memAccessPkg::addrT ramAddr;
    logic ramWr;
    logic [7:0] ramDout;
    int writeCount;

    logic [7:0] refMem [memAccessPkg::addrT];   // bytes last stored, absent reads as zero
    integer seed;
    int caseErrs;
    int passed;
    int failed;

    dcacheTop #(.indexBits(cacheGeomPkg::defaultIndexBits)) dut (
        .clk(clk), .rst(rst), .rdy(rdy), .lsEn(lsEn), .req(req), .ramDin(ramDin),
        .done(done), .ldData(ldData), .ramAddr(ramAddr), .ramWr(ramWr), .ramDout(ramDout)
    );

    ramModel ram (
        .clk(clk), .addr(ramAddr), .wr(ramWr), .din(ramDout), .dout(ramDin),
        .writeCount(writeCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int bytesOf(input memAccessPkg::accessLen len);
        case (len)
            memAccessPkg::lenByte: return 1;
            memAccessPkg::lenHalf: return 2;
            default:               return 4;
        endcase
    endfunction

    task automatic applyStore(input memAccessPkg::lsReq r);
        for (int i = 0; i < bytesOf(r.len); i++) begin
            refMem[r.addr + memAccessPkg::addrT'(i)] = r.sdata[8*i +: 8];
        end
    endtask

    // little endian, zero extended
    function automatic memAccessPkg::wordT predictLoad(input memAccessPkg::lsReq r);
        memAccessPkg::wordT w;
        memAccessPkg::addrT a;
        w = '0;
        for (int i = 0; i < bytesOf(r.len); i++) begin
            a = r.addr + memAccessPkg::addrT'(i);
            if (refMem.exists(a)) w[8*i +: 8] = refMem[a];
        end
        return w;
    endfunction

    task automatic checkLoad(input string name, input memAccessPkg::wordT got,
                             input memAccessPkg::wordT exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            caseErrs++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            caseErrs++;
        end
    endtask

    // done is sampled at the rising edge, before the edge updates it
    task automatic waitDone(output int cycles, output bit timedOut);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!done && cycles < timeoutCycles);
        timedOut = !done;
    endtask

    task automatic holdStall(input int n);
        rdy <= 1'b0;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (done) begin
                $display("done pulsed while rdy was low");
                caseErrs++;
            end
            @(negedge clk);
        end
        rdy <= 1'b1;
    endtask

    task automatic recordResult(input string name);
        if (caseErrs == 0) begin
            passed++;
            $display("%s ok", name);
        end else begin
            failed++;
            $display("%s FAILED", name);
        end
        caseErrs = 0;
    endtask

    initial begin
        int fd;
        int caseNo;
        int cycles;
        int wrStart;
        bit timedOut;
        string line;
        memAccessPkg::lsReq cur;
        logic [31:0] op;
        logic [31:0] lenCol;
        logic [31:0] addrCol;
        logic [31:0] data;
        logic [31:0] expVal;
        logic [31:0] latCol;
        logic [31:0] wrCol;
        logic [31:0] stallCol;

        seed = 52;
        passed = 0;
        failed = 0;
        caseErrs = 0;
        timedOut = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        lsEn = 1'b0;
        req = '0;

        // done and ramWr stay low through reset and until the first request
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (done || ramWr) begin
                $display("done or ramWr went high before the first request");
                caseErrs++;
            end
            if (i == 4) begin
                @(negedge clk);
                rst <= 1'b0;
            end
        end
        recordResult("reset state");

        fd = $fopen("sim/dcacheCases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/dcacheCases.txt");
            failed++;
        end else begin
            caseNo = 0;
            while (!$feof(fd) && !timedOut) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%h %h %h %h %h %h %h %h", op, lenCol, addrCol, data,
                            expVal, latCol, wrCol, stallCol) != 8) continue;
                caseNo++;
                cur.rw = op[0];
                cur.len = memAccessPkg::accessLen'(lenCol[1:0]);
                cur.addr = addrCol[cacheGeomPkg::addrBits-1:0];
                cur.sdata = data;

                @(negedge clk);
                wrStart = writeCount;
                req <= cur;
                lsEn <= 1'b1;
                @(negedge clk);
                lsEn <= 1'b0;
                if (stallCol != 0) holdStall(2 + $unsigned($random(seed)) % 6);
                waitDone(cycles, timedOut);

                if (timedOut) begin
                    $display("case %0d: done did not arrive within %0d cycles", caseNo,
                             timeoutCycles);
                    caseErrs++;
                end else begin
                    if (cur.rw) begin
                        applyStore(cur);
                    end else begin
                        if (predictLoad(cur) !== expVal) begin
                            $display("case %0d: case file value disagrees with the byte model",
                                     caseNo);
                            caseErrs++;
                        end
                        checkLoad("ldData", ldData, expVal);
                    end
                    if (latCol != 0) checkCount("done latency", cycles, latCol);
                    checkCount("ramWr bytes", writeCount - wrStart, wrCol);
                end
                recordResult($sformatf("case %0d", caseNo));
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && passed > 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/dcacheCases.txt */
# op (0 load, 1 store)  len (0 byte, 1 half, 2 word)  addr  data  expected load
# latency (0 unchecked)  RAM bytes written  stall; all hex
1 2 00100 12345678 00000000 1 0 0
0 2 00100 00000000 12345678 1 0 0
1 0 00101 000000aa 00000000 1 0 0
1 1 00102 0000beef 00000000 1 0 0
1 0 00103 00000011 00000000 1 0 0
1 0 00100 00000022 00000000 1 0 0
1 1 00100 00005566 00000000 1 0 0
1 0 00102 000000c3 00000000 1 0 0
0 2 00100 00000000 11c35566 1 0 0
0 1 00102 00000000 000011c3 1 0 0
0 0 00101 00000000 00000055 1 0 0
0 0 00103 00000000 00000011 1 0 0
1 2 00104 cafef00d 00000000 1 0 0
1 2 00204 0badc0de 00000000 0 4 0
0 2 00104 00000000 cafef00d 0 4 0
0 2 00204 00000000 0badc0de 0 0 0
1 0 00305 000000a5 00000000 0 1 0
1 1 0030a 00001234 00000000 0 2 0
1 2 30010 87654321 00000000 0 4 0
1 0 30020 0000005a 00000000 0 1 0
0 2 00304 00000000 0000a500 0 0 0
0 1 0030a 00000000 00001234 0 0 0
0 2 30010 00000000 87654321 0 0 0
1 2 00108 13572468 00000000 0 0 1
0 1 0010a 00000000 00001357 0 0 1
0 2 00308 00000000 12340000 0 4 1
0 2 00108 00000000 13572468 0 0 0

/* dcacheSub.f */
common/cacheGeomPkg.sv
common/memAccessPkg.sv
dcache/dcacheArray.sv
dcache/laneAlign.sv
dcache/dcacheCtrl.sv
design/memByteSeq.sv
design/dcacheTop.sv
sim/ramModel.sv
sim/dcacheTb.sv
